//--- Alu.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module Alu
    import mcpuPkg::*;
(
    input  IdExT             idEx,
    input  logic [`XLEN-1:0] memFwd,
    input  logic [`XLEN-1:0] wbFwd,
    input  FwdSelE           fwdA,
    input  FwdSelE           fwdB,
    output logic [`XLEN-1:0] result
);

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;

    // Load data never reaches an ALU operand, the stall prevents it
    function automatic logic [`XLEN-1:0] fwdMux(input FwdSelE sel, input logic [`XLEN-1:0] regVal,
                                                input logic [`XLEN-1:0] memVal,
                                                input logic [`XLEN-1:0] wbVal);
        case (sel)
            FwdMem:  return memVal;
            FwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA  = fwdMux(fwdA, idEx.rdata1, memFwd, wbFwd);
    assign opB  = fwdMux(fwdB, idEx.rdata2, memFwd, wbFwd);
    assign srcA = idEx.ctrl.srcAPc ? idEx.pc : opA;
    assign srcB = idEx.ctrl.link ? `XLEN'd4 : (idEx.ctrl.srcBImm ? idEx.imm : opB);

    always_comb begin
        case (idEx.ctrl.aluOp)
            AluAdd:   result = srcA + srcB;
            AluSub:   result = srcA - srcB;
            AluAnd:   result = srcA & srcB;
            AluOr:    result = srcA | srcB;
            AluXor:   result = srcA ^ srcB;
            AluSlt:   result = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            AluPassB: result = srcB;
            default:  result = '0;
        endcase
    end

endmodule

//--- CtrlUnit.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module CtrlUnit
    import mcpuPkg::*;
(
    input  IfIdT             ifId,
    input  logic [`XLEN-1:0] rdata1,
    input  logic [`XLEN-1:0] rdata2,
    output CtrlT             ctrl,
    output logic [`XLEN-1:0] imm,
    output logic             doJump,
    output logic [`XLEN-1:0] jumpPc
);

    logic [`XLEN-1:0] inst;
    logic [2:0]       funct3;
    logic             taken;

    assign inst   = ifId.inst;
    assign funct3 = inst[14:12];

    always_comb begin
        ctrl  = '0;
        imm   = '0;
        taken = 1'b0;
        case (inst[6:0])
            `OP_R: begin
                case (funct3)
                    3'b000:  ctrl.aluOp = inst[30] ? AluSub : AluAdd;
                    3'b111:  ctrl.aluOp = AluAnd;
                    3'b110:  ctrl.aluOp = AluOr;
                    3'b100:  ctrl.aluOp = AluXor;
                    3'b010:  ctrl.aluOp = AluSlt;
                    default: ctrl.aluOp = AluAdd;
                endcase
                ctrl.useRs1   = 1'b1;
                ctrl.useRs2   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OP_I, `OP_LOAD: begin
                imm            = {{20{inst[31]}}, inst[31:20]};
                ctrl.srcBImm   = 1'b1;
                ctrl.useRs1    = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = inst[6:0] == `OP_LOAD;
            end
            `OP_LUI: begin
                imm           = {inst[31:12], 12'b0};
                ctrl.aluOp    = AluPassB;
                ctrl.srcBImm  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OP_STORE: begin
                imm           = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                ctrl.srcBImm  = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.useRs1   = 1'b1;
                ctrl.useRs2   = 1'b1;
            end
            `OP_BRANCH: begin
                imm         = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                ctrl.useRs1 = 1'b1;
                ctrl.useRs2 = 1'b1;
                // BEQ and BNE only
                taken = (funct3 == 3'b000 && rdata1 == rdata2)
                     || (funct3 == 3'b001 && rdata1 != rdata2);
            end
            `OP_JAL: begin
                imm           = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                ctrl.srcAPc   = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
                taken         = 1'b1;
            end
            default: ctrl = '0;
        endcase
        // Writes to x0 are dropped here, so no later stage sees them
        if (inst[11:7] == 5'd0) begin
            ctrl.regWrite = 1'b0;
        end
    end

    assign doJump = taken;
    assign jumpPc = ifId.pc + imm;

endmodule

//--- DataRam.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module DataRam (
    input  logic             clk,
    input  logic             we,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rdata
);

    localparam int DmemAw = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]  mem [`DMEM_WORDS];
    logic [DmemAw-1:0] idx;

    // Word index, byte offset ignored
    assign idx = addr[DmemAw+1:2];

    always_ff @(negedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

//--- FetchUnit.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module FetchUnit
    import mcpuPkg::*;
(
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            stall,
    input  logic                            doJump,
    input  logic [`XLEN-1:0]                jumpPc,
    input  logic                            imemWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0]  imemAddr,
    input  logic [`XLEN-1:0]                imemData,
    output IfIdT                            ifOut
);

    localparam int ImemAw = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imem [`IMEM_WORDS];

    // Program load port, used while the core sits in reset
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= doJump ? jumpPc : pc + `XLEN'd4;
        end
    end

    assign ifOut = '{pc: pc, inst: imem[pc[ImemAw+1:2]]};

endmodule

//--- HazardUnit.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module HazardUnit
    import mcpuPkg::*;
(
    input  logic [`XLEN-1:0] ifIdInst,
    input  IdExT             idEx,
    input  ExMemT            exMem,
    input  MemWbT            memWb,
    input  logic             doJump,
    output logic             stall,
    output logic             flushIfId,
    output logic             flushIdEx,
    output FwdSelE           fwdA,
    output FwdSelE           fwdB,
    output FwdSelE           fwdStore
);

    logic [6:0] opcode;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       readsRs1;
    logic       readsRs2;

    assign opcode = ifIdInst[6:0];
    assign rs1    = ifIdInst[19:15];
    assign rs2    = ifIdInst[24:20];

    assign readsRs1 = opcode inside {`OP_R, `OP_I, `OP_LOAD, `OP_STORE, `OP_BRANCH};
    // Store data is excluded, it takes the load data from memory later
    assign readsRs2 = opcode inside {`OP_R, `OP_BRANCH};

    assign stall = idEx.ctrl.memRead && idEx.rd != 5'd0
                && ((readsRs1 && rs1 == idEx.rd) || (readsRs2 && rs2 == idEx.rd));
    assign flushIdEx = stall;
    assign flushIfId = doJump && !stall;

    // regWrite is never set for x0, so no zero check is needed
    function automatic FwdSelE pickSrc(input logic used, input logic [4:0] rs,
                                       input ExMemT mem, input MemWbT wb);
        if (used && mem.regWrite && mem.rd == rs) begin
            return mem.memRead ? FwdLoad : FwdMem;
        end else if (used && wb.regWrite && wb.rd == rs) begin
            return FwdWb;
        end
        return FwdReg;
    endfunction

    always_comb begin
        fwdA     = pickSrc(idEx.ctrl.useRs1, idEx.rs1, exMem, memWb);
        fwdB     = pickSrc(idEx.ctrl.useRs2, idEx.rs2, exMem, memWb);
        fwdStore = pickSrc(idEx.ctrl.memWrite, idEx.rs2, exMem, memWb);
    end

endmodule

//--- Mcpu.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module Mcpu
    import mcpuPkg::*;
(
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           imemWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0] imemAddr,
    input  logic [`XLEN-1:0]               imemData,
    output WbObsT                          wbObs,
    output StoreObsT                       storeObs
);

    IfIdT  ifData, ifId;
    IdExT  idExD, idEx;
    ExMemT exMemD, exMem;
    MemWbT memWbD, memWb;

    CtrlT             ctrl;
    logic [`XLEN-1:0] imm, jumpPc, rdata1, rdata2;
    logic [`XLEN-1:0] aluRes, storeData, loadData, wbData;
    logic             doJump, stall, flushIfId, flushIdEx;
    FwdSelE           fwdA, fwdB, fwdStore;

    // Fetch
    FetchUnit u_FetchUnit (
        .clk, .arstN, .stall, .doJump, .jumpPc,
        .imemWe, .imemAddr, .imemData, .ifOut(ifData)
    );

    PipeReg #(.Payload(IfIdT)) u_IfId (
        .clk, .arstN, .en(!stall), .flush(flushIfId), .d(ifData), .q(ifId)
    );

    // Decode
    CtrlUnit u_CtrlUnit (.ifId, .rdata1, .rdata2, .ctrl, .imm, .doJump, .jumpPc);

    RegFile u_RegFile (
        .clk, .arstN, .we(memWb.regWrite), .waddr(memWb.rd), .wdata(wbData),
        .raddr1(ifId.inst[19:15]), .raddr2(ifId.inst[24:20]), .rdata1, .rdata2
    );

    HazardUnit u_HazardUnit (
        .ifIdInst(ifId.inst), .idEx, .exMem, .memWb, .doJump,
        .stall, .flushIfId, .flushIdEx, .fwdA, .fwdB, .fwdStore
    );

    assign idExD = '{pc: ifId.pc, rdata1: rdata1, rdata2: rdata2, imm: imm,
                     rs1: ifId.inst[19:15], rs2: ifId.inst[24:20], rd: ifId.inst[11:7],
                     ctrl: ctrl};

    PipeReg #(.Payload(IdExT)) u_IdEx (
        .clk, .arstN, .en(1'b1), .flush(flushIdEx), .d(idExD), .q(idEx)
    );

    // Execute
    Alu u_Alu (
        .idEx, .memFwd(exMem.aluRes), .wbFwd(wbData), .fwdA, .fwdB, .result(aluRes)
    );

    assign storeData = (fwdStore == FwdLoad) ? loadData :
                       (fwdStore == FwdMem)  ? exMem.aluRes :
                       (fwdStore == FwdWb)   ? wbData : idEx.rdata2;

    assign exMemD = '{aluRes: aluRes, storeData: storeData, rd: idEx.rd,
                      regWrite: idEx.ctrl.regWrite, memRead: idEx.ctrl.memRead,
                      memWrite: idEx.ctrl.memWrite};

    PipeReg #(.Payload(ExMemT)) u_ExMem (
        .clk, .arstN, .en(1'b1), .flush(1'b0), .d(exMemD), .q(exMem)
    );

    // Memory
    DataRam u_DataRam (
        .clk, .we(exMem.memWrite), .addr(exMem.aluRes), .wdata(exMem.storeData),
        .rdata(loadData)
    );

    assign memWbD = '{aluRes: exMem.aluRes, loadData: loadData, rd: exMem.rd,
                      regWrite: exMem.regWrite, memRead: exMem.memRead};

    PipeReg #(.Payload(MemWbT)) u_MemWb (
        .clk, .arstN, .en(1'b1), .flush(1'b0), .d(memWbD), .q(memWb)
    );

    // Writeback
    assign wbData = memWb.memRead ? memWb.loadData : memWb.aluRes;

    assign wbObs    = '{valid: memWb.regWrite, rd: memWb.rd, data: wbData};
    assign storeObs = '{valid: exMem.memWrite, addr: exMem.aluRes, data: exMem.storeData};

endmodule

//--- Mcpu_assert.sv
`timescale 1ns/1ps

module Mcpu_assert
    import mcpuPkg::*;
(
    input logic     clk,
    input logic     arstN,
    input WbObsT    wbObs,
    input StoreObsT storeObs,
    input logic     stall,
    input logic     doJump,
    input IfIdT     ifId
);

    logic [2:0] cycleCount;

    // Saturating count of cycles since reset release
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cycleCount <= '0;
        end else if (cycleCount != 3'd7) begin
            cycleCount <= cycleCount + 3'd1;
        end
    end

    wbNotZero: assert property (@(posedge clk) disable iff (!arstN)
        wbObs.valid |-> wbObs.rd != 5'd0)
        else $error("writeback reported for register zero");

    // Decode holds its instruction through a stall
    stallHoldsDecode: assert property (@(posedge clk) disable iff (!arstN)
        stall |=> $stable(ifId))
        else $error("decode register changed during a stall");

    // Taken jump leaves a bubble in decode
    jumpFlushesDecode: assert property (@(posedge clk) disable iff (!arstN)
        (doJump && !stall) |=> (ifId == '0))
        else $error("instruction after a taken jump reached decode");

    // First instruction reaches memory in the fourth cycle
    noEarlyStore: assert property (@(posedge clk) disable iff (!arstN)
        (cycleCount < 3'd3) |-> !storeObs.valid)
        else $error("store seen before the fourth cycle after reset");

endmodule

//--- PipeReg.sv
`timescale 1ns/1ps

module PipeReg #(
    parameter type Payload = logic
) (
    input  logic   clk,
    input  logic   arstN,
    input  logic   en,
    input  logic   flush,
    input  Payload d,
    output Payload q
);

    // Zero payload is a bubble with every control bit clear
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

//--- RegFile.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module RegFile (
    input  logic             clk,
    input  logic             arstN,
    input  logic             we,
    input  logic [4:0]       waddr,
    input  logic [`XLEN-1:0] wdata,
    input  logic [4:0]       raddr1,
    input  logic [4:0]       raddr2,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2
);

    logic [`XLEN-1:0] regs [1:31];

    // Falling edge write lets decode see a same-cycle writeback
    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- mcpuPkg.sv
`include "mcpu_consts.svh"

package mcpuPkg;

    typedef enum logic [2:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluPassB
    } AluOpE;

    // Operand source for execute and store data
    typedef enum logic [1:0] {
        FwdReg, FwdMem, FwdWb, FwdLoad
    } FwdSelE;

    typedef struct packed {
        AluOpE aluOp;
        logic  srcAPc;
        logic  srcBImm;
        // B operand is 4, for the JAL return address
        logic  link;
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  useRs1;
        logic  useRs2;
    } CtrlT;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } IfIdT;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] rdata1;
        logic [`XLEN-1:0] rdata2;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        CtrlT             ctrl;
    } IdExT;

    typedef struct packed {
        logic [`XLEN-1:0] aluRes;
        logic [`XLEN-1:0] storeData;
        logic [4:0]       rd;
        logic             regWrite;
        logic             memRead;
        logic             memWrite;
    } ExMemT;

    typedef struct packed {
        logic [`XLEN-1:0] aluRes;
        logic [`XLEN-1:0] loadData;
        logic [4:0]       rd;
        logic             regWrite;
        logic             memRead;
    } MemWbT;

    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } WbObsT;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } StoreObsT;

endpackage

//--- mcpu_consts.svh
`ifndef MCPU_CONSTS_SVH
`define MCPU_CONSTS_SVH

// Datapath and address width
`define XLEN 32

// Memory depths in words
`define IMEM_WORDS 128
`define DMEM_WORDS 128

// RV32I major opcodes
`define OP_R      7'b0110011
`define OP_I      7'b0010011
`define OP_LUI    7'b0110111
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111

`endif

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tbMcpu \
    --Mdir "$BUILD_DIR" -o simMcpu
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/simMcpu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

//--- sources.f
+incdir+.
mcpuPkg.sv
PipeReg.sv
FetchUnit.sv
CtrlUnit.sv
RegFile.sv
HazardUnit.sv
Alu.sv
DataRam.sv
Mcpu.sv
Mcpu_assert.sv
tbMcpu.sv

//--- tbMcpu.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module tbMcpu
    import mcpuPkg::*;
();

    localparam int          ClkPeriod   = 40;
    localparam int          DriveDelay  = 2;
    localparam int          ImemAw      = $clog2(`IMEM_WORDS);
    localparam logic [31:0] Nop         = 32'h0000_0013;
    localparam int          LoadCycles  = `IMEM_WORDS + 2;
    localparam int          RunCycles   = 40;
    localparam int          DrainCycles = 8;
    localparam int          NumTests    = 5;
    localparam int          WatchdogCycles =
        NumTests * (LoadCycles + RunCycles + DrainCycles) + 100;

    logic              clk;
    logic              arstN;
    logic              imemWe;
    logic [ImemAw-1:0] imemAddr;
    logic [31:0]       imemData;
    WbObsT             wbObs;
    StoreObsT          storeObs;

    integer      seed;
    int          errorCount;
    int          checkCount;
    logic [31:0] prog [$];
    WbObsT       wbExp [$];
    WbObsT       wbGot [$];
    StoreObsT    storeExp [$];
    StoreObsT    storeGot [$];

    Mcpu u_Mcpu (
        .clk, .arstN, .imemWe, .imemAddr, .imemData, .wbObs, .storeObs
    );

    bind Mcpu Mcpu_assert u_McpuAssert (
        .clk(clk), .arstN(arstN), .wbObs(wbObs), .storeObs(storeObs),
        .stall(stall), .doJump(doJump), .ifId(ifId)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    // Observation ports are stable mid-cycle
    always @(negedge clk) begin
        if (arstN && wbObs.valid) begin
            wbGot.push_back(wbObs);
        end
        if (arstN && storeObs.valid) begin
            storeGot.push_back(storeObs);
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] signExt12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] rInst(input int funct7, input int funct3, input int rd,
                                          input int rs1, input int rs2);
        return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], `OP_R};
    endfunction

    function automatic logic [31:0] iInst(input int imm, input int rs1, input int funct3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] storeInst(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] branchInst(input int funct3, input int rs1, input int rs2,
                                               input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], funct3[2:0], off[4:1], off[11],
                `OP_BRANCH};
    endfunction

    function automatic logic [31:0] luiInst(input int rd, input int upper);
        return {upper[31:12], rd[4:0], `OP_LUI};
    endfunction

    function automatic logic [31:0] jalInst(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OP_JAL};
    endfunction

    task automatic checkEq(input string what, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        checkCount++;
        if (expVal !== actVal) begin
            errorCount++;
            $display("error: %s expected 0x%08h actual 0x%08h", what, expVal, actVal);
        end
    endtask

    task automatic expectWb(input int rd, input logic [31:0] data);
        WbObsT ev;
        ev.valid = 1'b1;
        ev.rd    = rd[4:0];
        ev.data  = data;
        wbExp.push_back(ev);
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        StoreObsT ev;
        ev.valid = 1'b1;
        ev.addr  = addr;
        ev.data  = data;
        storeExp.push_back(ev);
    endtask

    // Load under reset, release, then compare events in program order
    task automatic runProgram(input string name);
        int waitCycles;
        @(posedge clk);
        #DriveDelay;
        arstN = 1'b0;
        wbGot.delete();
        storeGot.delete();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            imemWe   = 1'b1;
            imemAddr = ImemAw'(i);
            imemData = (i < prog.size()) ? prog[i] : Nop;
            @(posedge clk);
            #DriveDelay;
        end
        imemWe = 1'b0;
        arstN  = 1'b1;
        waitCycles = 0;
        while ((wbGot.size() < wbExp.size() || storeGot.size() < storeExp.size())
               && waitCycles < RunCycles) begin
            @(posedge clk);
            waitCycles++;
        end
        // Trailing no-ops must stay silent
        repeat (DrainCycles) @(posedge clk);
        checkEq($sformatf("%s writeback count", name), wbExp.size(), wbGot.size());
        for (int i = 0; i < wbExp.size() && i < wbGot.size(); i++) begin
            checkEq($sformatf("%s wb %0d rd", name, i), 32'(wbExp[i].rd), 32'(wbGot[i].rd));
            checkEq($sformatf("%s wb %0d data", name, i), wbExp[i].data, wbGot[i].data);
        end
        checkEq($sformatf("%s store count", name), storeExp.size(), storeGot.size());
        for (int i = 0; i < storeExp.size() && i < storeGot.size(); i++) begin
            checkEq($sformatf("%s store %0d addr", name, i), storeExp[i].addr,
                    storeGot[i].addr);
            checkEq($sformatf("%s store %0d data", name, i), storeExp[i].data,
                    storeGot[i].data);
        end
        prog.delete();
        wbExp.delete();
        storeExp.delete();
    endtask

    task automatic aluOpsTest();
        logic [31:0] r [1:10];
        logic [31:0] rnd;
        logic [31:0] immA;
        logic [31:0] immB;
        logic [31:0] upper;
        rnd   = $random(seed);
        immA  = signExt12(rnd[11:0]);
        rnd   = $random(seed);
        immB  = signExt12(rnd[11:0]);
        rnd   = $random(seed);
        upper = rnd & 32'hffff_f000;
        r[1]  = immA;
        r[2]  = r[1] + immB;
        r[3]  = r[1] + r[2];
        r[4]  = r[3] - r[1];
        r[5]  = r[4] & r[3];
        r[6]  = r[5] | r[2];
        r[7]  = r[6] ^ r[4];
        r[8]  = ($signed(r[7]) < $signed(r[1])) ? 32'd1 : 32'd0;
        r[9]  = upper;
        r[10] = r[9] + r[8];
        prog.push_back(iInst(immA, 0, 0, 1, `OP_I));
        prog.push_back(iInst(immB, 1, 0, 2, `OP_I));
        prog.push_back(rInst(0, 0, 3, 1, 2));
        prog.push_back(rInst(32, 0, 4, 3, 1));
        prog.push_back(rInst(0, 7, 5, 4, 3));
        prog.push_back(rInst(0, 6, 6, 5, 2));
        prog.push_back(rInst(0, 4, 7, 6, 4));
        prog.push_back(rInst(0, 2, 8, 7, 1));
        prog.push_back(luiInst(9, upper));
        prog.push_back(rInst(0, 0, 10, 9, 8));
        for (int i = 1; i <= 10; i++) begin
            expectWb(i, r[i]);
        end
        runProgram("alu ops");
    endtask

    task automatic loadUseTest();
        prog.push_back(iInst(32'h2a5, 0, 0, 1, `OP_I));
        prog.push_back(iInst(16, 0, 0, 2, `OP_I));
        prog.push_back(storeInst(0, 1, 2));
        prog.push_back(iInst(0, 2, 2, 3, `OP_LOAD));
        prog.push_back(rInst(0, 0, 4, 3, 1));
        expectWb(1, 32'h2a5);
        expectWb(2, 32'd16);
        expectWb(3, 32'h2a5);
        expectWb(4, 32'h2a5 + 32'h2a5);
        expectStore(32'd16, 32'h2a5);
        runProgram("load use");
    endtask

    task automatic storeFwdTest();
        prog.push_back(iInst(32'h5a3, 0, 0, 5, `OP_I));
        prog.push_back(storeInst(8, 5, 0));
        expectWb(5, signExt12(12'h5a3));
        expectStore(32'd8, signExt12(12'h5a3));
        runProgram("store forward");
    endtask

    // Operands are set up at least three instructions before each branch
    task automatic branchTest();
        prog.push_back(iInst(5, 0, 0, 1, `OP_I));
        prog.push_back(iInst(5, 0, 0, 2, `OP_I));
        prog.push_back(iInst(7, 0, 0, 3, `OP_I));
        prog.push_back(Nop);
        prog.push_back(Nop);
        prog.push_back(branchInst(0, 1, 2, 8));
        prog.push_back(iInst(1, 0, 0, 10, `OP_I));
        prog.push_back(iInst(2, 0, 0, 11, `OP_I));
        prog.push_back(branchInst(1, 1, 2, 8));
        prog.push_back(iInst(3, 0, 0, 12, `OP_I));
        prog.push_back(branchInst(1, 1, 3, 8));
        prog.push_back(iInst(4, 0, 0, 13, `OP_I));
        prog.push_back(iInst(5, 0, 0, 14, `OP_I));
        expectWb(1, 32'd5);
        expectWb(2, 32'd5);
        expectWb(3, 32'd7);
        expectWb(11, 32'd2);
        expectWb(12, 32'd3);
        expectWb(14, 32'd5);
        runProgram("branches");
    endtask

    task automatic jalTest();
        prog.push_back(iInst(9, 0, 0, 1, `OP_I));
        prog.push_back(jalInst(5, 12));
        prog.push_back(iInst(1, 0, 0, 6, `OP_I));
        prog.push_back(iInst(2, 0, 0, 7, `OP_I));
        prog.push_back(jalInst(0, 8));
        prog.push_back(iInst(3, 0, 0, 8, `OP_I));
        prog.push_back(iInst(4, 0, 0, 9, `OP_I));
        expectWb(1, 32'd9);
        expectWb(5, 32'd4 + 32'd4);
        expectWb(9, 32'd4);
        runProgram("jal");
    endtask

    initial begin
        arstN      = 1'b0;
        imemWe     = 1'b0;
        imemAddr   = '0;
        imemData   = '0;
        seed       = 42;
        errorCount = 0;
        checkCount = 0;
        aluOpsTest();
        loadUseTest();
        storeFwdTest();
        branchTest();
        jalTest();
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
